// ==== verilog.f ====
common/vec_pkg.sv
vector_register_file/vector_register_file.sv
rtl/vector_alu.sv
rtl/vector_issue_ctrl.sv
rtl/vector_unit_top.sv
test/vector_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vector_unit

sources:
  - files:
      - common/vec_pkg.sv
      - vector_register_file/vector_register_file.sv
      - rtl/vector_alu.sv
      - rtl/vector_issue_ctrl.sv
      - rtl/vector_unit_top.sv
  - target: test
    files:
      - test/vector_unit_tb.sv

// ==== test/vector_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_unit_tb;

	import vec_pkg::*;

	localparam int ACK_TIMEOUT = 20;
	localparam int ISSUE_LATENCY = 3;

	logic         clk = 1'b0;
	logic         rst_i;
	logic         req_i;
	logic         ack_o;
	vop_t         op_i;
	strand_t      strand_i;
	reg_num_t     dst_i;
	reg_num_t     src1_i;
	reg_num_t     src2_i;
	lane_t        imm_i;
	lane_mask_t   mask_i;
	vector_t      result_o;

	vector_t      model [0:NUM_VREGS-1];	// expected register contents.
	integer       seed = 32'h8c37c264;

	vector_unit_top dut0
	(
		.clk      (clk),
		.rst_i    (rst_i),
		.req_i    (req_i),
		.ack_o    (ack_o),
		.op_i     (op_i),
		.strand_i (strand_i),
		.dst_i    (dst_i),
		.src1_i   (src1_i),
		.src2_i   (src2_i),
		.imm_i    (imm_i),
		.mask_i   (mask_i),
		.result_o (result_o)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_lane(input lane_t actual, input lane_t expected, input int lane,
			input string what);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0t ns: %s lane %0d got %h expected %h",
				$time, what, lane, actual, expected));
	endtask

	task automatic compare_vector(input vector_t actual, input vector_t expected,
			input string what);
		for (int l = 0; l < NUM_LANES; l++)
			compare_lane(actual[l*LANE_WIDTH +: LANE_WIDTH],
				expected[l*LANE_WIDTH +: LANE_WIDTH], l, what);
	endtask

	// expected value of one lane.
	function automatic lane_t model_lane(input vop_t op, input lane_t a, input lane_t b,
			input lane_t imm);
		case (op)
			VOP_ADD:  return a + b;
			VOP_SUB:  return a - b;
			VOP_AND:  return a & b;
			VOP_OR:   return a | b;
			VOP_XOR:  return a ^ b;
			VOP_SHL:  return a << b[4:0];
			VOP_SHR:  return a >> b[4:0];
			default:  return imm;
		endcase
	endfunction

	function automatic vector_t model_result(input vop_t op, input vector_t a, input vector_t b,
			input lane_t imm);
		vector_t r;
		for (int l = 0; l < NUM_LANES; l++)
			r[l*LANE_WIDTH +: LANE_WIDTH] = model_lane(op, a[l*LANE_WIDTH +: LANE_WIDTH],
				b[l*LANE_WIDTH +: LANE_WIDTH], imm);
		return r;
	endfunction

	// one full four-phase transfer from falling edge to falling edge.
	task automatic issue(input vop_t op, input strand_t strand, input reg_num_t dst,
			input reg_num_t src1, input reg_num_t src2, input lane_t imm,
			input lane_mask_t mask, input int hold, input string what);
		vector_t     expected;
		vector_t     held;
		vreg_idx_t   wr_idx;
		int          cycles;
		expected = model_result(op, model[{strand, src1}], model[{strand, src2}], imm);
		op_i = op;
		strand_i = strand;
		dst_i = dst;
		src1_i = src1;
		src2_i = src2;
		imm_i = imm;
		mask_i = mask;
		req_i = 1'b1;
		cycles = 0;
		while (ack_o !== 1'b1)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				fail_run($sformatf("%s: timed out waiting for ack_o to rise", what));
		end
		if (cycles != ISSUE_LATENCY)
			fail_run($sformatf("%s: ack_o rose after %0d cycles instead of %0d",
				what, cycles, ISSUE_LATENCY));
		compare_vector(result_o, expected, what);
		held = result_o;
		for (int i = 0; i < hold; i++)
		begin
			@(negedge clk);
			if (ack_o !== 1'b1)
				fail_run($sformatf("%s: ack_o dropped while req_i was held high", what));
			compare_vector(result_o, held, "held result");
		end
		req_i = 1'b0;
		cycles = 0;
		while (ack_o !== 1'b0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				fail_run($sformatf("%s: timed out waiting for ack_o to fall", what));
		end
		wr_idx = {strand, dst};
		for (int l = 0; l < NUM_LANES; l++)
			if (mask[l])
				model[wr_idx][l*LANE_WIDTH +: LANE_WIDTH] = expected[l*LANE_WIDTH +: LANE_WIDTH];
	endtask

	task automatic read_back(input strand_t strand, input reg_num_t r);
		issue(VOP_OR, strand, r, r, r, '0, '0, 0, "readback");	// mask zero, no write.
	endtask

	task automatic load_random_vector(input strand_t strand, input reg_num_t r);
		for (int l = 0; l < NUM_LANES; l++)
			issue(VOP_MOVI, strand, r, r, r, lane_t'($random(seed)), lane_mask_t'(1) << l, 0,
				"lane broadcast");
	endtask

	task automatic check_reset_state();
		if (ack_o !== 1'b0)
			fail_run("ack_o is not low after reset");
		compare_vector(result_o, '0, "result after reset");
	endtask

	task automatic broadcast_all();
		for (int s = 0; s < NUM_STRANDS; s++)
			for (int r = 0; r < REGS_PER_STRAND; r++)
				issue(VOP_MOVI, strand_t'(s), reg_num_t'(r), '0, '0,
					{16'h5a00 | 16'(s), 16'hc3c0 ^ 16'(r)}, '1, 0, "broadcast");
		for (int s = 0; s < NUM_STRANDS; s++)
			for (int r = 0; r < REGS_PER_STRAND; r++)
				read_back(strand_t'(s), reg_num_t'(r));
	endtask

	task automatic arith_logic();
		load_random_vector(2'd1, 5'd1);
		load_random_vector(2'd1, 5'd2);
		issue(VOP_ADD, 2'd1, 5'd3, 5'd1, 5'd2, '0, '1, 0, "add");
		issue(VOP_SUB, 2'd1, 5'd3, 5'd1, 5'd2, '0, '1, 0, "sub");
		issue(VOP_AND, 2'd1, 5'd3, 5'd1, 5'd2, '0, '1, 0, "and");
		issue(VOP_OR, 2'd1, 5'd3, 5'd1, 5'd2, '0, '1, 0, "or");
		issue(VOP_XOR, 2'd1, 5'd3, 5'd1, 5'd2, '0, '1, 0, "xor");
		// carry out and borrow past bit 31.
		issue(VOP_MOVI, 2'd1, 5'd4, '0, '0, 32'hffff_ffff, '1, 0, "broadcast");
		issue(VOP_MOVI, 2'd1, 5'd5, '0, '0, 32'h0000_0002, '1, 0, "broadcast");
		issue(VOP_MOVI, 2'd1, 5'd6, '0, '0, 32'h0000_0000, '1, 0, "broadcast");
		issue(VOP_ADD, 2'd1, 5'd7, 5'd4, 5'd5, '0, '1, 0, "add wrap");
		issue(VOP_SUB, 2'd1, 5'd8, 5'd6, 5'd5, '0, '1, 0, "sub wrap");
		read_back(2'd1, 5'd7);
		read_back(2'd1, 5'd8);
	endtask

	task automatic shift_amounts();
		load_random_vector(2'd2, 5'd1);
		load_random_vector(2'd2, 5'd2);
		issue(VOP_SHL, 2'd2, 5'd3, 5'd1, 5'd2, '0, '1, 0, "shl");
		issue(VOP_SHR, 2'd2, 5'd4, 5'd1, 5'd2, '0, '1, 0, "shr");
		issue(VOP_MOVI, 2'd2, 5'd5, '0, '0, 32'h8000_0001, '1, 0, "broadcast");
		issue(VOP_MOVI, 2'd2, 5'd6, '0, '0, 32'hffff_ffe3, '1, 0, "broadcast");	// shift by 3.
		issue(VOP_SHL, 2'd2, 5'd7, 5'd5, 5'd6, '0, '1, 0, "shl upper bits");
		issue(VOP_SHR, 2'd2, 5'd8, 5'd5, 5'd6, '0, '1, 0, "shr upper bits");
	endtask

	task automatic masked_write();
		lane_mask_t mask;
		mask = lane_mask_t'($random(seed));
		mask[0] = 1'b1;	// keep it partial.
		mask[15] = 1'b0;
		issue(VOP_MOVI, 2'd3, 5'd9, '0, '0, lane_t'($random(seed)), mask, 0, "masked write");
		read_back(2'd3, 5'd9);
		issue(VOP_XOR, 2'd3, 5'd9, 5'd9, 5'd10, '0, '0, 0, "zero mask write");
		read_back(2'd3, 5'd9);
	endtask

	task automatic back_pressure();
		issue(VOP_ADD, 2'd0, 5'd20, 5'd1, 5'd2, '0, '1, 6, "held add");
		read_back(2'd0, 5'd20);
	endtask

	initial
	begin
		rst_i = 1'b1;
		req_i = 1'b0;
		op_i = VOP_ADD;
		strand_i = '0;
		dst_i = '0;
		src1_i = '0;
		src2_i = '0;
		imm_i = '0;
		mask_i = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		check_reset_state();
		broadcast_all();
		arith_logic();
		shift_amounts();
		masked_write();
		back_pressure();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/vector_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_unit_top
(
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    req_i,
	output logic                   ack_o,
	input  vec_pkg::vop_t          op_i,
	input  vec_pkg::strand_t       strand_i,
	input  vec_pkg::reg_num_t      dst_i,
	input  vec_pkg::reg_num_t      src1_i,
	input  vec_pkg::reg_num_t      src2_i,
	input  vec_pkg::lane_t         imm_i,
	input  vec_pkg::lane_mask_t    mask_i,
	output vec_pkg::vector_t       result_o
);

	import vec_pkg::*;

	vreg_idx_t    sel1;
	vreg_idx_t    sel2;
	vector_t      value1;
	vector_t      value2;
	vop_t         alu_op;
	lane_t        alu_imm;
	vector_t      alu_result;
	vreg_idx_t    write_reg;
	lane_mask_t   write_mask;
	logic         write_en;

	vector_issue_ctrl ctrl0
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.req_i        (req_i),
		.ack_o        (ack_o),
		.op_i         (op_i),
		.strand_i     (strand_i),
		.dst_i        (dst_i),
		.src1_i       (src1_i),
		.src2_i       (src2_i),
		.imm_i        (imm_i),
		.mask_i       (mask_i),
		.sel1_o       (sel1),
		.sel2_o       (sel2),
		.alu_op_o     (alu_op),
		.alu_imm_o    (alu_imm),
		.alu_result_i (alu_result),
		.write_reg_o  (write_reg),
		.write_mask_o (write_mask),
		.write_en_o   (write_en),
		.result_o     (result_o)
	);

	vector_register_file vrf0
	(
		.clk           (clk),
		.rst_i         (rst_i),
		.sel1_i        (sel1),
		.sel2_i        (sel2),
		.value1_o      (value1),
		.value2_o      (value2),
		.write_reg_i   (write_reg),
		.write_value_i (alu_result),	// masked writeback of the alu result.
		.write_mask_i  (write_mask),
		.write_en_i    (write_en)
	);

	vector_alu alu0
	(
		.op_i     (alu_op),
		.a_i      (value1),
		.b_i      (value2),
		.imm_i    (alu_imm),
		.result_o (alu_result)
	);

endmodule

`default_nettype wire

// ==== rtl/vector_issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_issue_ctrl
(
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    req_i,
	output logic                   ack_o,
	input  vec_pkg::vop_t          op_i,
	input  vec_pkg::strand_t       strand_i,
	input  vec_pkg::reg_num_t      dst_i,
	input  vec_pkg::reg_num_t      src1_i,
	input  vec_pkg::reg_num_t      src2_i,
	input  vec_pkg::lane_t         imm_i,
	input  vec_pkg::lane_mask_t    mask_i,
	output vec_pkg::vreg_idx_t     sel1_o,
	output vec_pkg::vreg_idx_t     sel2_o,
	output vec_pkg::vop_t          alu_op_o,
	output vec_pkg::lane_t         alu_imm_o,
	input  vec_pkg::vector_t       alu_result_i,
	output vec_pkg::vreg_idx_t     write_reg_o,
	output vec_pkg::lane_mask_t    write_mask_o,
	output logic                   write_en_o,
	output vec_pkg::vector_t       result_o
);

	import vec_pkg::*;

	typedef enum logic [1:0]
	{
		IDLE,
		READ,
		EXEC,
		DONE
	} state_t;

	state_t       state_q;
	logic         ack_q;
	vector_t      result_q;

	vop_t         op_q;
	strand_t      strand_q;
	reg_num_t     dst_q;
	reg_num_t     src1_q;
	reg_num_t     src2_q;
	lane_t        imm_q;
	lane_mask_t   mask_q;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= IDLE;
			ack_q <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (req_i)
						state_q <= READ;
				end
				READ:
					state_q <= EXEC;	// operands land in the register file.
				EXEC:
				begin
					state_q <= DONE;
					ack_q <= 1'b1;
					result_q <= alu_result_i;
				end
				DONE:
				begin
					// host holds req for back-pressure.
					if (!req_i)
					begin
						state_q <= IDLE;
						ack_q <= 1'b0;
					end
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// capture the instruction on issue.
	always_ff @(posedge clk)
	begin
		if (state_q == IDLE && req_i)
		begin
			op_q <= op_i;
			strand_q <= strand_i;
			dst_q <= dst_i;
			src1_q <= src1_i;
			src2_q <= src2_i;
			imm_q <= imm_i;
			mask_q <= mask_i;
		end
	end

	assign sel1_o = {strand_q, src1_q};
	assign sel2_o = {strand_q, src2_q};
	assign alu_op_o = op_q;
	assign alu_imm_o = imm_q;

	assign write_reg_o = {strand_q, dst_q};
	assign write_mask_o = mask_q;
	assign write_en_o = (state_q == EXEC);

	assign ack_o = ack_q;
	assign result_o = result_q;

	a_ack_in_done: assert property (
		@(posedge clk) disable iff (rst_i)
		ack_o |-> state_q == DONE
	);

	// one write per instruction and the ack right after it.
	a_single_write: assert property (
		@(posedge clk) disable iff (rst_i)
		write_en_o |=> !write_en_o && ack_o
	);

endmodule

`default_nettype wire

// ==== rtl/vector_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_alu
(
	input  vec_pkg::vop_t      op_i,
	input  vec_pkg::vector_t   a_i,
	input  vec_pkg::vector_t   b_i,
	input  vec_pkg::lane_t     imm_i,
	output vec_pkg::vector_t   result_o
);

	import vec_pkg::*;

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		lane_t                    a_lane;
		lane_t                    b_lane;
		lane_t                    r_lane;
		logic [SHAMT_WIDTH-1:0]   shamt;

		assign a_lane = a_i[g*LANE_WIDTH +: LANE_WIDTH];
		assign b_lane = b_i[g*LANE_WIDTH +: LANE_WIDTH];
		assign shamt = b_lane[SHAMT_WIDTH-1:0];	// low five bits only.

		always_comb
		begin
			case (op_i)
				VOP_ADD:
					r_lane = a_lane + b_lane;	// wraps at 32 bits.
				VOP_SUB:
					r_lane = a_lane - b_lane;
				VOP_AND:
					r_lane = a_lane & b_lane;
				VOP_OR:
					r_lane = a_lane | b_lane;
				VOP_XOR:
					r_lane = a_lane ^ b_lane;
				VOP_SHL:
					r_lane = a_lane << shamt;
				VOP_SHR:
					r_lane = a_lane >> shamt;	// logical, zero fill.
				VOP_MOVI:
					r_lane = imm_i;
				default:
					r_lane = '0;
			endcase
		end

		assign result_o[g*LANE_WIDTH +: LANE_WIDTH] = r_lane;
	end

endmodule

`default_nettype wire

// ==== vector_register_file/vector_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_register_file
(
	input  wire                    clk,
	input  wire                    rst_i,
	input  vec_pkg::vreg_idx_t     sel1_i,
	input  vec_pkg::vreg_idx_t     sel2_i,
	output vec_pkg::vector_t       value1_o,
	output vec_pkg::vector_t       value2_o,
	input  vec_pkg::vreg_idx_t     write_reg_i,
	input  vec_pkg::vector_t       write_value_i,
	input  vec_pkg::lane_mask_t    write_mask_i,
	input  wire                    write_en_i
);

	import vec_pkg::*;

	// each lane is its own memory so the mask maps to a per-lane write enable.
	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		lane_t mem [0:NUM_VREGS-1];
		lane_t rd1_q;
		lane_t rd2_q;

		always_ff @(posedge clk)
		begin
			if (write_en_i && write_mask_i[g])
				mem[write_reg_i] <= write_value_i[g*LANE_WIDTH +: LANE_WIDTH];
		end

		// read before write on a collision.
		always_ff @(posedge clk)
		begin
			if (rst_i)
			begin
				rd1_q <= '0;
				rd2_q <= '0;
			end
			else
			begin
				rd1_q <= mem[sel1_i];
				rd2_q <= mem[sel2_i];
			end
		end

		assign value1_o[g*LANE_WIDTH +: LANE_WIDTH] = rd1_q;
		assign value2_o[g*LANE_WIDTH +: LANE_WIDTH] = rd2_q;
	end

	a_write_idx_known: assert property (
		@(posedge clk) disable iff (rst_i)
		write_en_i |-> !$isunknown(write_reg_i)
	);

endmodule

`default_nettype wire

// ==== common/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

	localparam int NUM_LANES = 16;
	localparam int LANE_WIDTH = 32;
	localparam int NUM_STRANDS = 4;
	localparam int REGS_PER_STRAND = 32;
	localparam int NUM_VREGS = NUM_STRANDS * REGS_PER_STRAND;

	localparam int VECTOR_WIDTH = NUM_LANES * LANE_WIDTH;
	localparam int STRAND_WIDTH = $clog2(NUM_STRANDS);
	localparam int REG_NUM_WIDTH = $clog2(REGS_PER_STRAND);
	localparam int VREG_IDX_WIDTH = $clog2(NUM_VREGS);
	localparam int SHAMT_WIDTH = $clog2(LANE_WIDTH);

	typedef logic [LANE_WIDTH-1:0] lane_t;

	// lane n sits at bits 32n+31 down to 32n.
	typedef logic [VECTOR_WIDTH-1:0] vector_t;

	typedef logic [NUM_LANES-1:0] lane_mask_t;

	// {strand, register number}.
	typedef logic [VREG_IDX_WIDTH-1:0] vreg_idx_t;

	typedef logic [STRAND_WIDTH-1:0] strand_t;

	typedef logic [REG_NUM_WIDTH-1:0] reg_num_t;

	typedef enum logic [2:0]
	{
		VOP_ADD  = 3'd0,
		VOP_SUB  = 3'd1,
		VOP_AND  = 3'd2,
		VOP_OR   = 3'd3,
		VOP_XOR  = 3'd4,
		VOP_SHL  = 3'd5,
		VOP_SHR  = 3'd6,
		VOP_MOVI = 3'd7	// broadcast immediate.
	} vop_t;

endpackage

`default_nettype wire
